//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // data path width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // bit positions of the instruction fields
    localparam int opc_lsb   = 0;
    localparam int f3_lsb    = 12;
    localparam int imm_u_lsb = 12;
    localparam int imm_i_lsb = 20;
    localparam int f7_lsb    = 25;

    // major opcodes kept in this stage
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_fp  = 7'b1010011;

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [6:0] f7_fadd = 7'b0000000;
    localparam logic [6:0] f7_fsub = 7'b0000100;

    // funct3 of the integer ops, sub/sra share a code with add/srl
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sub  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_sra  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

endpackage

`default_nettype wire

//--- logic/ex_ctrl_pkg.sv
`default_nettype none

package ex_ctrl_pkg;

    // single precision field widths
    localparam int fp_exp_w = 8;
    localparam int fp_man_w = 23;
    localparam int fp_bias  = 127;

    // which unit an issued op goes to, none marks an illegal word
    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_fpu  = 2'd2
    } unit_e;

    // integer ALU functions
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui just forwards operand b
        alu_pass_b = 4'd10
    } alu_op_e;

    // 7 bit control word carried with every issued op
    typedef struct packed {
        unit_e   unit;
        alu_op_e alu_op;
        logic    fp_sub;
    } ex_ctrl_t;

endpackage

`default_nettype wire

//--- logic/ex_op_if.sv
`default_nettype none

// one issued operation, decode to units and result stage
interface ex_op_if;

    // high for one cycle per operation
    logic                  issue;
    ex_ctrl_pkg::ex_ctrl_t ctrl;
    rv_isa_pkg::word_t     op_a;
    rv_isa_pkg::word_t     op_b;

    // decode side
    modport source (
        output issue, ctrl, op_a, op_b
    );

    // units and result stage
    modport sink (
        input issue, ctrl, op_a, op_b
    );

endinterface

`default_nettype wire

//--- logic/ex_decode.sv
`default_nettype none

module ex_decode
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     launch,
    input  word_t    inst,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    frs1_data,
    input  word_t    frs2_data,
    ex_op_if.source  op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    ex_ctrl_t   ctrl_d;
    word_t      op_a_d;
    word_t      op_b_d;

    // instruction fields
    assign opcode = inst[opc_lsb +: 7];
    assign funct3 = inst[f3_lsb +: 3];
    assign funct7 = inst[f7_lsb +: 7];

    // sign extended I immediate, U immediate with low 12 bits zero
    assign imm_i = {{20{inst[xlen-1]}}, inst[imm_i_lsb +: 12]};
    assign imm_u = {inst[imm_u_lsb +: 20], 12'd0};

    always_comb begin
        // default is illegal with register operands
        ctrl_d = '{unit: unit_none, alu_op: alu_add, fp_sub: 1'b0};
        op_a_d = rs1_data;
        op_b_d = rs2_data;
        case (opcode)
            opc_op: begin
                ctrl_d.unit = unit_alu;
                // funct7 and funct3 together pick the op
                case ({funct7, funct3})
                    {f7_base, f3_add}:  ctrl_d.alu_op = alu_add;
                    {f7_alt,  f3_sub}:  ctrl_d.alu_op = alu_sub;
                    {f7_base, f3_sll}:  ctrl_d.alu_op = alu_sll;
                    {f7_base, f3_slt}:  ctrl_d.alu_op = alu_slt;
                    {f7_base, f3_sltu}: ctrl_d.alu_op = alu_sltu;
                    {f7_base, f3_xor}:  ctrl_d.alu_op = alu_xor;
                    {f7_base, f3_srl}:  ctrl_d.alu_op = alu_srl;
                    {f7_alt,  f3_sra}:  ctrl_d.alu_op = alu_sra;
                    {f7_base, f3_or}:   ctrl_d.alu_op = alu_or;
                    {f7_base, f3_and}:  ctrl_d.alu_op = alu_and;
                    default:            ctrl_d.unit   = unit_none;
                endcase
            end
            opc_op_imm: begin
                ctrl_d.unit = unit_alu;
                op_b_d      = imm_i;
                case (funct3)
                    f3_add:  ctrl_d.alu_op = alu_add;
                    f3_slt:  ctrl_d.alu_op = alu_slt;
                    f3_sltu: ctrl_d.alu_op = alu_sltu;
                    f3_xor:  ctrl_d.alu_op = alu_xor;
                    f3_or:   ctrl_d.alu_op = alu_or;
                    f3_and:  ctrl_d.alu_op = alu_and;
                    f3_sll: begin
                        ctrl_d.alu_op = alu_sll;
                        if (funct7 != f7_base) ctrl_d.unit = unit_none;
                    end
                    default: begin
                        // srli or srai, bit 30 picks arithmetic
                        ctrl_d.alu_op = (funct7 == f7_alt) ? alu_sra : alu_srl;
                        if (funct7 != f7_base && funct7 != f7_alt) begin
                            ctrl_d.unit = unit_none;
                        end
                    end
                endcase
            end
            opc_lui: begin
                ctrl_d.unit   = unit_alu;
                ctrl_d.alu_op = alu_pass_b;
                op_b_d        = imm_u;
            end
            opc_op_fp: begin
                op_a_d = frs1_data;
                op_b_d = frs2_data;
                // rounding mode field is ignored, always truncate
                if (funct7 == f7_fadd || funct7 == f7_fsub) begin
                    ctrl_d.unit   = unit_fpu;
                    ctrl_d.fp_sub = (funct7 == f7_fsub);
                end
            end
            default: ctrl_d.unit = unit_none;
        endcase
    end

    // issue pulse and control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op.issue <= 1'b0;
            op.ctrl  <= '{unit: unit_none, alu_op: alu_add, fp_sub: 1'b0};
        end else begin
            op.issue <= launch;
            if (launch) op.ctrl <= ctrl_d;
        end
    end

    // operands
    always_ff @(posedge clk) begin
        if (launch) begin
            op.op_a <= op_a_d;
            op.op_b <= op_b_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/int_alu.sv
`default_nettype none

module int_alu
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    ex_op_if.sink   op,
    output logic    alu_valid,
    output word_t   alu_result
);

    word_t      res_d;
    logic [4:0] shamt;
    logic       take;

    // only low five bits shift
    assign shamt = op.op_b[4:0];
    assign take  = op.issue && (op.ctrl.unit == unit_alu);

    always_comb begin
        res_d = '0;
        case (op.ctrl.alu_op)
            alu_add:    res_d = op.op_a + op.op_b;
            alu_sub:    res_d = op.op_a - op.op_b;
            alu_sll:    res_d = op.op_a << shamt;
            // signed compare per rv32i
            alu_slt:    res_d[0] = $signed(op.op_a) < $signed(op.op_b);
            alu_sltu:   res_d[0] = op.op_a < op.op_b;
            alu_xor:    res_d = op.op_a ^ op.op_b;
            alu_srl:    res_d = op.op_a >> shamt;
            alu_sra:    res_d = $signed(op.op_a) >>> shamt;
            alu_or:     res_d = op.op_a | op.op_b;
            alu_and:    res_d = op.op_a & op.op_b;
            alu_pass_b: res_d = op.op_b;
            default:    res_d = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) alu_result <= res_d;
    end

endmodule

`default_nettype wire

//--- logic/fp_adder.sv
`default_nettype none

module fp_adder
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    ex_op_if.sink   op,
    output logic    fp_valid,
    output word_t   fp_result
);

    // all ones exponent, used for infinity
    localparam int exp_max = 2 * fp_bias + 1;
    localparam int lz_w    = $clog2(fp_man_w + 1);

    logic                sign_a, sign_b;
    logic [fp_exp_w-1:0] exp_a, exp_b;
    logic [fp_man_w:0]   man_a, man_b;
    logic                a_big;
    logic [fp_exp_w-1:0] big_exp, diff;
    logic [fp_man_w:0]   big_man, small_man;
    logic [fp_man_w+1:0] sum_d;
    logic                take;

    logic                s1_valid;
    logic                s1_sign;
    logic [fp_exp_w-1:0] s1_exp;
    logic [fp_man_w+1:0] s1_sum;

    logic [lz_w-1:0]     lz;
    logic [fp_man_w:0]   norm_man;
    logic [fp_exp_w+1:0] exp_n;
    word_t               res_d;

    assign take = op.issue && (op.ctrl.unit == unit_fpu);

    // unpack, zero exponent reads as zero, flip b sign on subtract
    assign sign_a = op.op_a[xlen-1];
    assign sign_b = op.op_b[xlen-1] ^ op.ctrl.fp_sub;
    assign exp_a  = op.op_a[fp_man_w +: fp_exp_w];
    assign exp_b  = op.op_b[fp_man_w +: fp_exp_w];
    assign man_a  = (exp_a == '0) ? '0 : {1'b1, op.op_a[fp_man_w-1:0]};
    assign man_b  = (exp_b == '0) ? '0 : {1'b1, op.op_b[fp_man_w-1:0]};

    // order by magnitude
    assign a_big     = {exp_a, man_a} >= {exp_b, man_b};
    assign big_exp   = a_big ? exp_a : exp_b;
    assign diff      = a_big ? exp_a - exp_b : exp_b - exp_a;
    assign big_man   = a_big ? man_a : man_b;
    // align smaller one, shifted out bits are lost
    assign small_man = (a_big ? man_b : man_a) >> diff;

    // magnitude add or subtract, big minus small never goes negative
    assign sum_d = (sign_a ^ sign_b) ? {1'b0, big_man} - {1'b0, small_man}
                                     : {1'b0, big_man} + {1'b0, small_man};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            fp_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            fp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_sign <= a_big ? sign_a : sign_b;
            s1_exp  <= big_exp;
            s1_sum  <= sum_d;
        end
        if (s1_valid) fp_result <= res_d;
    end

    // stage 2, leading zero count, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i <= fp_man_w; i++) begin
            if (s1_sum[i]) lz = lz_w'(fp_man_w - i);
        end
    end

    always_comb begin
        if (s1_sum[fp_man_w+1]) begin
            // carry out, shift right once
            norm_man = s1_sum[fp_man_w+1:1];
            exp_n    = {2'b00, s1_exp} + 1'b1;
        end else begin
            norm_man = s1_sum[fp_man_w:0] << lz;
            exp_n    = {2'b00, s1_exp} - {{(fp_exp_w + 2 - lz_w){1'b0}}, lz};
        end
        // zero sum or exponent at or below zero gives +0
        if (s1_sum == '0 || exp_n[fp_exp_w+1] || exp_n == '0) begin
            res_d = '0;
        end else if (exp_n >= (fp_exp_w + 2)'(exp_max)) begin
            // overflow to signed infinity
            res_d = {s1_sign, {fp_exp_w{1'b1}}, {fp_man_w{1'b0}}};
        end else begin
            res_d = {s1_sign, exp_n[fp_exp_w-1:0], norm_man[fp_man_w-1:0]};
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_result.sv
`default_nettype none

module ex_result
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    output logic    launch,
    ex_op_if.sink   op,
    input  logic    alu_valid,
    input  logic    fp_valid,
    input  word_t   alu_result,
    input  word_t   fp_result,
    output logic    ack,
    output logic    illegal,
    output word_t   result
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_done = 2'd2
    } state_e;

    state_e state;
    logic   bad_issue;

    // decode found no unit for this word
    assign bad_issue = op.issue && (op.ctrl.unit == unit_none);

    // start one op when idle and asked
    assign launch = (state == st_idle) && req;
    assign ack    = (state == st_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (req) state <= st_busy;
                st_busy: if (alu_valid || fp_valid || bad_issue) state <= st_done;
                // hold ack until requester lets go
                st_done: if (!req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // capture whichever unit answered, held through ack
    always_ff @(posedge clk) begin
        if (state == st_busy) begin
            if (alu_valid) begin
                result  <= alu_result;
                illegal <= 1'b0;
            end else if (fp_valid) begin
                result  <= fp_result;
                illegal <= 1'b0;
            end else if (bad_issue) begin
                result  <= '0;
                illegal <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_unit_top.sv
`default_nettype none

module ex_unit_top
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  word_t inst,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t frs1_data,
    input  word_t frs2_data,
    output logic  ack,
    output logic  illegal,
    output word_t result
);

    logic  launch;
    logic  alu_valid;
    logic  fp_valid;
    word_t alu_result;
    word_t fp_result;

    // issued op shared by both units and the result stage
    ex_op_if u_op_if ();

    ex_decode u_ex_decode (
        .clk       (clk),
        .rst       (rst),
        .launch    (launch),
        .inst      (inst),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .frs1_data (frs1_data),
        .frs2_data (frs2_data),
        .op        (u_op_if.source)
    );

    // integer path, one cycle
    int_alu u_int_alu (
        .clk        (clk),
        .rst        (rst),
        .op         (u_op_if.sink),
        .alu_valid  (alu_valid),
        .alu_result (alu_result)
    );

    // float add/sub, two cycles
    fp_adder u_fp_adder (
        .clk       (clk),
        .rst       (rst),
        .op        (u_op_if.sink),
        .fp_valid  (fp_valid),
        .fp_result (fp_result)
    );

    // handshake and result mux
    ex_result u_ex_result (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .launch     (launch),
        .op         (u_op_if.sink),
        .alu_valid  (alu_valid),
        .fp_valid   (fp_valid),
        .alu_result (alu_result),
        .fp_result  (fp_result),
        .ack        (ack),
        .illegal    (illegal),
        .result     (result)
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`default_nettype none

// free running clock and power on reset for the testbench
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/tb_ex_unit.sv
`default_nettype none

module tb_ex_unit
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // cycles allowed for each ack edge
    localparam int ack_timeout = 20;
    // all ones exponent field
    localparam int exp_inf     = (1 << fp_exp_w) - 1;

    logic  clk;
    logic  rst;
    logic  req;
    logic  ack;
    logic  illegal;
    word_t inst;
    word_t rs1_data;
    word_t rs2_data;
    word_t frs1_data;
    word_t frs2_data;
    word_t result;

    logic [31:0] seed;
    // expected responses in issue order
    word_t       exp_result_q[$];
    logic        exp_illegal_q[$];
    logic        ack_seen;
    int          op_count;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    ex_unit_top u_ex_unit_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .inst      (inst),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .frs1_data (frs1_data),
        .frs2_data (frs2_data),
        .ack       (ack),
        .illegal   (illegal),
        .result    (result)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // advances the shared seed
    function automatic word_t next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    // single precision add with zero exponent read as zero and truncation throughout
    function automatic word_t fp_add_ref(input word_t a, input word_t b, input logic sub);
        logic                sa;
        logic                sb;
        logic                sr;
        logic [fp_exp_w-1:0] ea;
        logic [fp_exp_w-1:0] eb;
        logic [fp_exp_w-1:0] e_big;
        logic [fp_exp_w-1:0] e_small;
        logic [fp_man_w:0]   ma;
        logic [fp_man_w:0]   mb;
        logic [fp_man_w:0]   m_big;
        logic [fp_man_w:0]   m_small;
        logic [fp_man_w+1:0] sum;
        int                  e;
        sa = a[xlen-1];
        sb = b[xlen-1] ^ sub;
        ea = a[fp_man_w +: fp_exp_w];
        eb = b[fp_man_w +: fp_exp_w];
        ma = (ea == '0) ? '0 : {1'b1, a[fp_man_w-1:0]};
        mb = (eb == '0) ? '0 : {1'b1, b[fp_man_w-1:0]};
        // larger magnitude sets the sign and exponent
        if (ea > eb || (ea == eb && ma >= mb)) begin
            sr      = sa;
            e_big   = ea;
            m_big   = ma;
            e_small = eb;
            m_small = mb;
        end else begin
            sr      = sb;
            e_big   = eb;
            m_big   = mb;
            e_small = ea;
            m_small = ma;
        end
        // bits shifted out on alignment are dropped
        m_small = m_small >> (e_big - e_small);
        if (sa == sb) sum = m_big + m_small;
        else sum = m_big - m_small;
        e = e_big;
        if (sum == '0) return '0;
        if (sum[fp_man_w+1]) begin
            sum = sum >> 1;
            e   = e + 1;
        end else begin
            while (!sum[fp_man_w]) begin
                sum = sum << 1;
                e   = e - 1;
            end
        end
        // underflow flushes to +0
        if (e <= 0) return '0;
        // overflow saturates to signed infinity
        if (e >= exp_inf) return {sr, {fp_exp_w{1'b1}}, {fp_man_w{1'b0}}};
        return {sr, e[fp_exp_w-1:0], sum[fp_man_w-1:0]};
    endfunction

    // rv32i integer op where alt picks sub or sra
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                      input word_t b);
        case (f3)
            f3_add: begin
                if (alt) return a - b;
                return a + b;
            end
            f3_sll:  return a << b[4:0];
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_sltu: return (a < b) ? 32'd1 : 32'd0;
            f3_xor:  return a ^ b;
            f3_srl: begin
                if (alt) return word_t'($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected result and illegal flag for one request
    function automatic word_t ref_exec(input word_t inst_w, input word_t rs1, input word_t rs2,
                                       input word_t frs1, input word_t frs2, output logic bad);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        word_t      imm;
        opc = inst_w[6:0];
        f3  = inst_w[14:12];
        f7  = inst_w[31:25];
        imm = {{20{inst_w[31]}}, inst_w[31:20]};
        bad = 1'b0;
        case (opc)
            opc_op: begin
                if (f7 == f7_base || (f7 == f7_alt && (f3 == f3_add || f3 == f3_srl))) begin
                    return alu_ref(f3, f7 == f7_alt, rs1, rs2);
                end
            end
            opc_op_imm: begin
                // shift immediates carry a funct7 field and there is no subi
                if (!(f3 == f3_sll && f7 != f7_base) &&
                    !(f3 == f3_srl && f7 != f7_base && f7 != f7_alt)) begin
                    return alu_ref(f3, f3 == f3_srl && f7 == f7_alt, rs1, imm);
                end
            end
            opc_lui: return {inst_w[31:12], 12'd0};
            opc_op_fp: begin
                if (f7 == f7_fadd) return fp_add_ref(frs1, frs2, 1'b0);
                if (f7 == f7_fsub) return fp_add_ref(frs1, frs2, 1'b1);
            end
            default: ;
        endcase
        // anything not handled above
        bad = 1'b1;
        return '0;
    endfunction

    // random normal float with exponent in 100..160
    function automatic word_t rand_normal();
        word_t               r;
        logic [fp_exp_w-1:0] e;
        r = next_rand();
        e = fp_exp_w'(100 + (r[31:24] % 61));
        return {r[fp_man_w], e, r[fp_man_w-1:0]};
    endfunction

    // one full four phase transfer starting 1 ns after an edge with ack low
    task automatic run_op(input word_t i_w, input word_t a, input word_t b, input word_t fa,
                          input word_t fb);
        word_t want;
        logic  want_bad;
        word_t held;
        logic  held_bad;
        int    hold;
        int    waited;
        want = ref_exec(i_w, a, b, fa, fb, want_bad);
        exp_result_q.push_back(want);
        exp_illegal_q.push_back(want_bad);
        inst      = i_w;
        rs1_data  = a;
        rs2_data  = b;
        frs1_data = fa;
        frs2_data = fb;
        req       = 1'b1;
        waited    = 0;
        while (ack !== 1'b1) begin
            if (waited == ack_timeout) begin
                $display("timeout: ack did not rise within %0d cycles of req", ack_timeout);
                stop_run();
            end
            @(posedge clk);
            #1;
            waited++;
        end
        held     = result;
        held_bad = illegal;
        // ack, result and illegal stay put while req is held
        hold = next_rand() % 3;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_flag("ack", ack, 1'b1);
            check_word("result", result, held);
            check_flag("illegal", illegal, held_bad);
        end
        req  = 1'b0;
        // inputs are free once req drops
        inst = next_rand();
        waited = 0;
        while (ack !== 1'b0) begin
            if (waited == ack_timeout) begin
                $display("timeout: ack did not fall within %0d cycles of req low", ack_timeout);
                stop_run();
            end
            @(posedge clk);
            #1;
            waited++;
        end
        op_count++;
    endtask

    // all ten op/funct combos with OP and OP-IMM alternating every ten
    task automatic run_int_ops();
        logic [2:0] f3;
        logic       alt;
        logic [6:0] f7;
        logic [6:0] opc;
        word_t      fill;
        for (int i = 0; i < 200; i++) begin
            case (i % 10)
                0: f3 = f3_add;
                1: f3 = f3_sub;
                2: f3 = f3_sll;
                3: f3 = f3_slt;
                4: f3 = f3_sltu;
                5: f3 = f3_xor;
                6: f3 = f3_srl;
                7: f3 = f3_sra;
                8: f3 = f3_or;
                default: f3 = f3_and;
            endcase
            alt  = (i % 10 == 1) || (i % 10 == 7);
            fill = next_rand();
            opc  = ((i / 10) % 2 == 0) ? opc_op : opc_op_imm;
            if (opc == opc_op || f3 == f3_sll || f3 == f3_srl) f7 = alt ? f7_alt : f7_base;
            else f7 = fill[31:25];
            run_op({f7, fill[24:15], f3, fill[11:7], opc}, next_rand(), next_rand(),
                   next_rand(), next_rand());
        end
    endtask

    task automatic run_lui_ops();
        word_t fill;
        for (int i = 0; i < 20; i++) begin
            fill = next_rand();
            run_op({fill[31:7], opc_lui}, next_rand(), next_rand(), next_rand(), next_rand());
        end
    endtask

    task automatic run_fp_ops();
        word_t fa;
        word_t fb;
        word_t fill;
        logic  sub;
        for (int i = 0; i < 100; i++) begin
            fill = next_rand();
            sub  = fill[7];
            fa   = rand_normal();
            fb   = rand_normal();
            // exact cancellation must come back +0
            if (i % 5 == 0) fb = sub ? fa : {~fa[xlen-1], fa[xlen-2:0]};
            // same exponent for a deep normalize
            else if (i % 5 == 1) fb[fp_man_w +: fp_exp_w] = fa[fp_man_w +: fp_exp_w];
            run_op({sub ? f7_fsub : f7_fadd, fill[24:12], fill[11:8], fill[6], opc_op_fp},
                   next_rand(), next_rand(), fa, fb);
        end
        fill = next_rand();
        // overflow to +inf and -inf
        run_op({f7_fadd, fill[24:7], opc_op_fp}, 32'd0, 32'd0, 32'h7f7fffff, 32'h7f7fffff);
        run_op({f7_fsub, fill[24:7], opc_op_fp}, 32'd0, 32'd0, 32'hff7fffff, 32'h7f7fffff);
        // zero exponent operand counts as zero
        run_op({f7_fadd, fill[24:7], opc_op_fp}, 32'd0, 32'd0, 32'h00400000, 32'hbfc00000);
        run_op({f7_fsub, fill[24:7], opc_op_fp}, 32'd0, 32'd0, 32'h3f800000, 32'h00012345);
    endtask

    task automatic run_illegal_ops();
        word_t fill;
        fill = next_rand();
        // unknown major opcode
        run_op({fill[31:7], 7'b1111111}, next_rand(), next_rand(), next_rand(), next_rand());
        // no alt form of and
        run_op({f7_alt, fill[24:15], f3_and, fill[11:7], opc_op}, next_rand(), next_rand(),
               next_rand(), next_rand());
        run_op({f7_alt, fill[24:15], f3_sll, fill[11:7], opc_op_imm}, next_rand(),
               next_rand(), next_rand(), next_rand());
        // fmul is not in this stage
        run_op({7'b0001000, fill[24:7], opc_op_fp}, next_rand(), next_rand(), next_rand(),
               next_rand());
    endtask

    // compares each response on the cycle ack first shows high
    initial begin
        ack_seen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (ack === 1'b1 && !ack_seen) begin
                if (exp_result_q.size() == 0) begin
                    $display("ack rose with no request outstanding");
                    stop_run();
                end else begin
                    check_word("result", result, exp_result_q.pop_front());
                    check_flag("illegal", illegal, exp_illegal_q.pop_front());
                end
            end
            ack_seen = (ack === 1'b1);
        end
    end

    initial begin : stimulus
        int waited;
        seed      = 32'h022d6e5f;
        op_count  = 0;
        req       = 1'b0;
        inst      = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        frs1_data = '0;
        frs2_data = '0;
        waited    = 0;
        while (rst !== 1'b0) begin
            if (waited == 10) begin
                $display("reset was not released within 10 cycles");
                stop_run();
            end
            @(posedge clk);
            #1;
            waited++;
        end
        // ack must not move while idle with req low
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag("ack", ack, 1'b0);
        end
        run_int_ops();
        run_lui_ops();
        run_fp_ops();
        run_illegal_ops();
        // back to back after an illegal word
        run_op(32'h00a00093, 32'd0, 32'd0, 32'd0, 32'd0);
        // no stray ack once the last transfer is done
        repeat (2) begin
            @(posedge clk);
            #1;
            check_flag("ack", ack, 1'b0);
        end
        $display("%0d operations completed", op_count);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/rv_isa_pkg.sv
logic/ex_ctrl_pkg.sv
logic/ex_op_if.sv
logic/ex_decode.sv
logic/int_alu.sv
logic/fp_adder.sv
logic/ex_result.sv
logic/ex_unit_top.sv
verification/tb_clk_gen.sv
verification/tb_ex_unit.sv

//--- Bender.yml
package:
  name: ex_unit

sources:
  # packages and interface first
  - logic/rv_isa_pkg.sv
  - logic/ex_ctrl_pkg.sv
  - logic/ex_op_if.sv
  - logic/ex_decode.sv
  - logic/int_alu.sv
  - logic/fp_adder.sv
  - logic/ex_result.sv
  - logic/ex_unit_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_ex_unit.sv
